//--- uart_pkg.sv
// Shared types, constants and FSM state encodings for the two-channel UART hub
package uart_pkg;

    // ------------------------------
    // Frame and channel types
    // ------------------------------

    // One serial data byte
    typedef logic [7:0] data_t;

    // Channel number, which also fixes the channel count
    typedef logic [0:0] channel_t;

    localparam int NUM_CHANNELS = 2 ** $bits(channel_t);

    // Samples per bit period
    localparam int OVERSAMPLE = 16;

    // Position inside one bit period, in sample ticks
    typedef logic [$clog2(OVERSAMPLE)-1:0] sample_cnt_t;

    // Data bit index inside a frame
    typedef logic [$clog2($bits(data_t))-1:0] bit_cnt_t;

    // ------------------------------
    // FSM encodings
    // ------------------------------

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

endpackage

//--- baud_tick_gen.sv
// Shared baud timing, produces the 16x sample tick and the aligned bit tick
`timescale 1ns/1ps

module baud_tick_gen #(
    parameter int CLOCK_HZ  = 10_000_000,
    parameter int BAUD_RATE = 156_250
) (
    input  logic clk,
    input  logic reset,
    output logic sample_tick,
    output logic bit_tick
);

    import uart_pkg::*;

    // Clock cycles per sample tick
    localparam int SAMPLE_DIV = CLOCK_HZ / (BAUD_RATE * OVERSAMPLE);
    localparam int DIV_W      = (SAMPLE_DIV > 1) ? $clog2(SAMPLE_DIV) : 1;

    logic [DIV_W-1:0] div_cnt;
    sample_cnt_t      os_cnt;
    logic             div_wrap;

    assign div_wrap = (div_cnt == DIV_W'(SAMPLE_DIV - 1));

    // Divider chain, bit tick is every 16th sample tick
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            div_cnt     <= '0;
            os_cnt      <= '0;
            sample_tick <= 1'b0;
            bit_tick    <= 1'b0;
        end else begin
            sample_tick <= 1'b0;
            bit_tick    <= 1'b0;
            if (div_wrap) begin
                div_cnt     <= '0;
                os_cnt      <= os_cnt + 1'b1;
                sample_tick <= 1'b1;
                bit_tick    <= (os_cnt == sample_cnt_t'(OVERSAMPLE - 1));
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

endmodule

//--- uart_rx.sv
// One channel receiver, turns an oversampled serial frame into a held byte
`timescale 1ns/1ps

module uart_rx (
    input  logic            clk,
    input  logic            reset,
    input  logic            enable,
    input  logic            sample_tick,
    input  logic            rx_line,
    output logic            byte_valid,
    output uart_pkg::data_t byte_data,
    input  logic            byte_ready,
    output logic            frame_error,
    output logic            overrun
);

    import uart_pkg::*;

    // Mid-bit after the start edge, then one full bit per sample point
    localparam sample_cnt_t MID_COUNT  = sample_cnt_t'(OVERSAMPLE / 2 - 1);
    localparam sample_cnt_t LAST_COUNT = sample_cnt_t'(OVERSAMPLE - 1);

    logic        rx_meta;
    logic        rx_sync;
    rx_state_e   state;
    sample_cnt_t cnt;
    bit_cnt_t    bit_idx;
    data_t       shift_reg;
    logic        stop_good;

    // ------------------------------
    // Two-flop synchronizer
    // ------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx_line;
            rx_sync <= rx_meta;
        end
    end

    // Valid stop bit found at this sample point
    assign stop_good = enable && sample_tick && (state == RX_STOP)
                       && (cnt == LAST_COUNT) && rx_sync;

    // ------------------------------
    // Frame FSM
    // ------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= RX_IDLE;
            cnt         <= '0;
            bit_idx     <= '0;
            frame_error <= 1'b0;
        end else if (!enable) begin
            state <= RX_IDLE;
        end else if (sample_tick) begin
            cnt <= cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    if (!rx_sync) begin
                        state <= RX_START;
                        cnt   <= '0;
                    end
                end
                RX_START: begin
                    if (cnt == MID_COUNT) begin
                        // Line back high at mid start bit means a glitch
                        state   <= rx_sync ? RX_IDLE : RX_DATA;
                        cnt     <= '0;
                        bit_idx <= '0;
                    end
                end
                RX_DATA: begin
                    if (cnt == LAST_COUNT) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == bit_cnt_t'($bits(data_t) - 1)) begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (cnt == LAST_COUNT) begin
                        state <= RX_IDLE;
                        if (!rx_sync) begin
                            frame_error <= 1'b1;
                        end
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // Data bits arrive LSB first
    always_ff @(posedge clk) begin
        if (sample_tick && (state == RX_DATA) && (cnt == LAST_COUNT)) begin
            shift_reg <= {rx_sync, shift_reg[7:1]};
        end
    end

    // ------------------------------
    // Holding register
    // ------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            byte_valid <= 1'b0;
            overrun    <= 1'b0;
        end else begin
            if (byte_ready) begin
                byte_valid <= 1'b0;
            end
            if (stop_good) begin
                byte_valid <= 1'b1;
                // Old byte still unread and not taken this cycle
                if (byte_valid && !byte_ready) begin
                    overrun <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (stop_good) begin
            byte_data <= shift_reg;
        end
    end

endmodule

//--- uart_tx.sv
// One channel transmitter, sends start bit, eight data bits LSB first, stop bit
`timescale 1ns/1ps

module uart_tx (
    input  logic            clk,
    input  logic            reset,
    input  logic            enable,
    input  logic            bit_tick,
    input  logic            load_valid,
    input  uart_pkg::data_t load_data,
    output logic            load_ready,
    output logic            tx_line
);

    import uart_pkg::*;

    tx_state_e state;
    logic      pending;
    bit_cnt_t  bit_idx;
    data_t     shift_reg;
    logic      accept;

    // Ready only when idle with nothing waiting for the next bit tick
    assign load_ready = enable && (state == TX_IDLE) && !pending;
    assign accept     = load_valid && load_ready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= TX_IDLE;
            pending <= 1'b0;
            bit_idx <= '0;
            tx_line <= 1'b1;
        end else begin
            if (accept) begin
                pending <= 1'b1;
            end
            if (bit_tick) begin
                case (state)
                    TX_IDLE: begin
                        if (pending) begin
                            pending <= 1'b0;
                            state   <= TX_START;
                            tx_line <= 1'b0;
                        end
                    end
                    TX_START: begin
                        state   <= TX_DATA;
                        bit_idx <= '0;
                        tx_line <= shift_reg[0];
                    end
                    TX_DATA: begin
                        if (bit_idx == bit_cnt_t'($bits(data_t) - 1)) begin
                            state   <= TX_STOP;
                            tx_line <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            tx_line <= shift_reg[1];
                        end
                    end
                    TX_STOP: begin
                        // Stop bit has now lasted a full period
                        state <= TX_IDLE;
                    end
                    default: state <= TX_IDLE;
                endcase
            end
        end
    end

    // Byte latch and shifter
    always_ff @(posedge clk) begin
        if (accept) begin
            shift_reg <= load_data;
        end else if (bit_tick && (state == TX_DATA)) begin
            shift_reg <= {1'b1, shift_reg[7:1]};
        end
    end

endmodule

//--- rx_arbiter.sv
// Round-robin merge of the channel receivers into the tagged host receive stream
`timescale 1ns/1ps

module rx_arbiter (
    input  logic                               clk,
    input  logic                               reset,
    input  logic [uart_pkg::NUM_CHANNELS-1:0]  req_valid,
    input  uart_pkg::data_t                    req_data0,
    input  uart_pkg::data_t                    req_data1,
    output logic [uart_pkg::NUM_CHANNELS-1:0]  req_ready,
    output logic                               rx_valid,
    output uart_pkg::data_t                    rx_data,
    output uart_pkg::channel_t                 rx_channel,
    input  logic                               rx_ready
);

    import uart_pkg::*;

    channel_t prio;
    channel_t other;
    channel_t gnt_ch;
    logic     can_load;
    logic     gnt_any;

    assign other = ~prio;

    // Buffer is free or drains this cycle
    assign can_load = !rx_valid || rx_ready;

    // ------------------------------
    // Grant selection
    // ------------------------------
    always_comb begin
        req_ready = '0;
        gnt_ch    = prio;
        if (can_load) begin
            if (req_valid[prio]) begin
                req_ready[prio] = 1'b1;
            end else if (req_valid[other]) begin
                req_ready[other] = 1'b1;
                gnt_ch           = other;
            end
        end
    end

    assign gnt_any = |req_ready;

    // Pointer moves past the channel just served
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            prio     <= '0;
            rx_valid <= 1'b0;
        end else begin
            if (rx_valid && rx_ready) begin
                rx_valid <= 1'b0;
            end
            if (gnt_any) begin
                rx_valid <= 1'b1;
                prio     <= ~gnt_ch;
            end
        end
    end

    // One-entry output buffer with its channel tag
    always_ff @(posedge clk) begin
        if (gnt_any) begin
            rx_data    <= gnt_ch[0] ? req_data1 : req_data0;
            rx_channel <= gnt_ch;
        end
    end

endmodule

//--- uart_hub.sv
// Top level of the two-channel UART hub, host streams in and serial lines out
`timescale 1ns/1ps

module uart_hub #(
    parameter int CLOCK_HZ  = 10_000_000,
    parameter int BAUD_RATE = 156_250
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic [uart_pkg::NUM_CHANNELS-1:0]  channel_enable,
    input  logic                               tx_valid,
    input  uart_pkg::data_t                    tx_data,
    input  uart_pkg::channel_t                 tx_channel,
    output logic                               tx_ready,
    output logic                               rx_valid,
    output uart_pkg::data_t                    rx_data,
    output uart_pkg::channel_t                 rx_channel,
    input  logic                               rx_ready,
    input  logic [uart_pkg::NUM_CHANNELS-1:0]  rx_line,
    output logic [uart_pkg::NUM_CHANNELS-1:0]  tx_line,
    output logic [uart_pkg::NUM_CHANNELS-1:0]  frame_error,
    output logic [uart_pkg::NUM_CHANNELS-1:0]  overrun
);

    import uart_pkg::*;

    logic                    sample_tick;
    logic                    bit_tick;
    logic [NUM_CHANNELS-1:0] load_valid;
    logic [NUM_CHANNELS-1:0] load_ready;
    logic [NUM_CHANNELS-1:0] byte_valid;
    logic [NUM_CHANNELS-1:0] byte_ready;
    data_t                   byte_data [NUM_CHANNELS];

    // Shared baud timing
    baud_tick_gen #(
        .CLOCK_HZ  (CLOCK_HZ),
        .BAUD_RATE (BAUD_RATE)
    ) baud_tick_gen_i (
        .clk         (clk),
        .reset       (reset),
        .sample_tick (sample_tick),
        .bit_tick    (bit_tick)
    );

    // Host transmit stream goes to the tagged channel
    assign tx_ready = load_ready[tx_channel];

    // ------------------------------
    // Per-channel serial ends
    // ------------------------------
    for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_chan
        assign load_valid[ch] = tx_valid && (tx_channel == channel_t'(ch));

        uart_tx uart_tx_i (
            .clk        (clk),
            .reset      (reset),
            .enable     (channel_enable[ch]),
            .bit_tick   (bit_tick),
            .load_valid (load_valid[ch]),
            .load_data  (tx_data),
            .load_ready (load_ready[ch]),
            .tx_line    (tx_line[ch])
        );

        uart_rx uart_rx_i (
            .clk         (clk),
            .reset       (reset),
            .enable      (channel_enable[ch]),
            .sample_tick (sample_tick),
            .rx_line     (rx_line[ch]),
            .byte_valid  (byte_valid[ch]),
            .byte_data   (byte_data[ch]),
            .byte_ready  (byte_ready[ch]),
            .frame_error (frame_error[ch]),
            .overrun     (overrun[ch])
        );
    end

    // Receivers share the host receive stream
    rx_arbiter rx_arbiter_i (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (byte_valid),
        .req_data0  (byte_data[0]),
        .req_data1  (byte_data[1]),
        .req_ready  (byte_ready),
        .rx_valid   (rx_valid),
        .rx_data    (rx_data),
        .rx_channel (rx_channel),
        .rx_ready   (rx_ready)
    );

endmodule

//--- tb_clock.sv
// Testbench clock and reset source, instantiated once by the hub testbench
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset held for a fixed number of rising edges
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

//--- uart_hub_properties.sv
// Concurrent checks on the hub host streams, bound into every uart_hub instance
`timescale 1ns/1ps

module uart_hub_properties (
    input logic                              clk,
    input logic                              reset,
    input logic                              rx_valid,
    input uart_pkg::data_t                   rx_data,
    input uart_pkg::channel_t                rx_channel,
    input logic                              rx_ready,
    input logic [uart_pkg::NUM_CHANNELS-1:0] byte_ready,
    input logic [uart_pkg::NUM_CHANNELS-1:0] load_ready,
    input logic [uart_pkg::NUM_CHANNELS-1:0] tx_line
);

    import uart_pkg::*;

    // Held receive byte stays put until the host takes it
    a_rx_stable: assert property (@(posedge clk) disable iff (reset)
        rx_valid && !rx_ready |=> rx_valid && $stable(rx_data) && $stable(rx_channel))
        else $error("rx stream changed before transfer");

    // At most one receiver granted per cycle
    a_one_grant: assert property (@(posedge clk) disable iff (reset)
        $onehot0(byte_ready))
        else $error("both receivers granted in one cycle");

    // Idle transmitters keep their lines in the mark state
    a_tx_idle: assert property (@(posedge clk) disable iff (reset)
        &load_ready |-> &tx_line)
        else $error("tx line low while both transmitters idle");

endmodule

bind uart_hub uart_hub_properties uart_hub_properties_i (
    .clk        (clk),
    .reset      (reset),
    .rx_valid   (rx_valid),
    .rx_data    (rx_data),
    .rx_channel (rx_channel),
    .rx_ready   (rx_ready),
    .byte_ready (byte_ready),
    .load_ready (load_ready),
    .tx_line    (tx_line)
);

//--- uart_hub_tb.sv
// Directed testbench for the UART hub, drives serial lines and host streams
`timescale 1ns/1ps

module uart_hub_tb;

    import uart_pkg::*;

    localparam int CLOCK_HZ     = 10_000_000;
    localparam int BAUD_RATE    = 156_250;
    localparam int BIT_CYCLES   = CLOCK_HZ / BAUD_RATE;
    localparam int FRAME_CYCLES = 10 * BIT_CYCLES;
    localparam int TIMEOUT      = 4 * FRAME_CYCLES;

    logic        clk;
    logic        reset;
    logic [1:0]  channel_enable;
    logic        tx_valid;
    data_t       tx_data;
    channel_t    tx_channel;
    logic        tx_ready;
    logic        rx_valid;
    data_t       rx_data;
    channel_t    rx_channel;
    logic        rx_ready;
    logic [1:0]  rx_line;
    logic [1:0]  tx_line;
    logic [1:0]  frame_error;
    logic [1:0]  overrun;

    // Arbiter pointer as the round-robin rule predicts it
    channel_t next_prio;

    tb_clock #(.PERIOD_NS(100), .RESET_CYCLES(2)) tb_clock_i (.clk(clk), .reset(reset));

    uart_hub #(
        .CLOCK_HZ  (CLOCK_HZ),
        .BAUD_RATE (BAUD_RATE)
    ) uart_hub_i (
        .clk(clk), .reset(reset), .channel_enable(channel_enable),
        .tx_valid(tx_valid), .tx_data(tx_data), .tx_channel(tx_channel),
        .tx_ready(tx_ready), .rx_valid(rx_valid), .rx_data(rx_data),
        .rx_channel(rx_channel), .rx_ready(rx_ready), .rx_line(rx_line),
        .tx_line(tx_line), .frame_error(frame_error), .overrun(overrun)
    );

    // ------------------------------
    // Helpers
    // ------------------------------
    task automatic fail_run(input string msg);
        $display("%s at %0t", msg, $time);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s got %0h expected %0h", $time, what, got, exp);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    task automatic send_frame(input int ch, input data_t d, input logic stop_bit);
        rx_line[ch] = 1'b0;
        repeat (BIT_CYCLES) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
            rx_line[ch] = d[i];
            repeat (BIT_CYCLES) @(negedge clk);
        end
        rx_line[ch] = stop_bit;
        repeat (BIT_CYCLES) @(negedge clk);
        rx_line[ch] = 1'b1;
    endtask

    task automatic read_frame(input int ch, output data_t d);
        int n;
        n = 0;
        while (tx_line[ch] !== 1'b0) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) fail_run("timeout waiting for start bit on tx_line");
        end
        repeat (BIT_CYCLES / 2) @(negedge clk);
        check("tx start bit", tx_line[ch], 1'b0);
        for (int i = 0; i < 8; i++) begin
            repeat (BIT_CYCLES) @(negedge clk);
            d[i] = tx_line[ch];
        end
        repeat (BIT_CYCLES) @(negedge clk);
        check("tx stop bit", tx_line[ch], 1'b1);
    endtask

    task automatic watch_line_high(input int ch, input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check("idle tx_line", tx_line[ch], 1'b1);
        end
    endtask

    // Host takes one byte, rx_ready must already be high
    task automatic expect_rx(input channel_t ch, input data_t d);
        int n;
        n = 0;
        while (rx_valid !== 1'b1) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) fail_run("timeout waiting for rx_valid");
        end
        check("rx_channel", rx_channel, ch);
        check("rx_data", rx_data, d);
        next_prio = ~ch;
        @(negedge clk);
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check("rx_valid quiet", rx_valid, 1'b0);
        end
    endtask

    // ------------------------------
    // Tests
    // ------------------------------
    task automatic test_receive();
        data_t d;
        d = 8'($urandom);
        rx_ready = 1'b1;
        // Byte shows up during the stop bit, so watch while sending
        fork
            send_frame(0, d, 1'b1);
            expect_rx(0, d);
        join
        check("frame_error", frame_error, 2'b00);
        check("overrun", overrun, 2'b00);
    endtask

    task automatic test_transmit();
        data_t d;
        data_t got;
        int n;
        d = 8'($urandom);
        tx_data    = d;
        tx_channel = 1'b1;
        n = 0;
        @(negedge clk);
        // Offer the byte once the transmitter reports ready
        while (tx_ready !== 1'b1) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) fail_run("timeout waiting for tx_ready");
        end
        tx_valid = 1'b1;
        @(negedge clk);
        tx_valid = 1'b0;
        check("tx_ready after accept", tx_ready, 1'b0);
        fork
            read_frame(1, got);
            watch_line_high(0, FRAME_CYCLES + 2 * BIT_CYCLES);
        join
        check("tx frame data", got, d);
    endtask

    task automatic test_arbitration();
        data_t d0;
        data_t d1;
        channel_t first;
        d0 = 8'($urandom);
        d1 = 8'($urandom);
        rx_ready = 1'b0;
        fork
            send_frame(0, d0, 1'b1);
            send_frame(1, d1, 1'b1);
        join
        repeat (BIT_CYCLES) @(negedge clk);
        first = next_prio;
        rx_ready = 1'b1;
        expect_rx(first, first ? d1 : d0);
        expect_rx(~first, first ? d0 : d1);
    endtask

    task automatic test_frame_error();
        rx_ready = 1'b1;
        fork
            send_frame(1, 8'($urandom), 1'b0);
            expect_quiet(2 * FRAME_CYCLES);
        join
        check("frame_error[1]", frame_error[1], 1'b1);
    endtask

    task automatic test_overrun();
        data_t d [3];
        rx_ready = 1'b0;
        for (int i = 0; i < 3; i++) begin
            d[i] = 8'($urandom);
            send_frame(0, d[i], 1'b1);
        end
        repeat (BIT_CYCLES) @(negedge clk);
        check("overrun[0]", overrun[0], 1'b1);
        rx_ready = 1'b1;
        expect_rx(0, d[0]);
        expect_rx(0, d[2]);
        expect_quiet(FRAME_CYCLES);
    endtask

    task automatic test_disable();
        channel_enable = 2'b01;
        tx_channel     = 1'b1;
        rx_ready       = 1'b1;
        @(negedge clk);
        check("tx_ready disabled", tx_ready, 1'b0);
        fork
            send_frame(1, 8'($urandom), 1'b1);
            expect_quiet(2 * FRAME_CYCLES);
        join
        channel_enable = 2'b11;
    endtask

    initial begin
        int n;
        void'($urandom(32'h729e_a273));
        channel_enable = 2'b11;
        tx_valid       = 1'b0;
        tx_data        = '0;
        tx_channel     = '0;
        rx_ready       = 1'b0;
        rx_line        = 2'b11;
        next_prio      = '0;
        n = 0;
        while (reset !== 1'b0) begin
            @(negedge clk);
            n++;
            if (n > 100) fail_run("reset never released");
        end
        repeat (4) @(negedge clk);
        test_receive();
        test_transmit();
        test_arbitration();
        test_frame_error();
        test_overrun();
        test_disable();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- compile.f
uart_pkg.sv
baud_tick_gen.sv
uart_rx.sv
uart_tx.sv
rx_arbiter.sv
uart_hub.sv
tb_clock.sv
uart_hub_properties.sv
uart_hub_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wall -f compile.f --top-module uart_hub_tb -o sim_uart_hub

out=$(./obj_dir/sim_uart_hub)
echo "$out"

if echo "$out" | grep -q "Simulation PASSED"; then
    exit 0
else
    exit 1
fi
